// ==== list.f ====
+incdir+verif
hw/ac_tx_pkg.sv
hw/tx_frame_mem.sv
hw/dma_write_decode.sv
hw/frame_queue_ctrl.sv
hw/read_select.sv
hw/ac_tx_buf_top.sv
verif/tb_ac_tx_buf.sv

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd860;

// shadow of the four AC RAMs and their write pointers
logic [DATA_W-1:0] shadow_mem [NUM_AC][DEPTH];
logic [ADDR_W-1:0] shadow_wptr [NUM_AC];

function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_bit()}; // one step per bit
	end
	return v;
endfunction

// payload bytes to whole words, plus the header, modulo the RAM depth
function automatic logic [ADDR_W-1:0] release_words(input logic [LEN_W-1:0] len);
	int words;
	words = (int'(len) + 3) / 4 + HDR_WORDS;
	return ADDR_W'(words % DEPTH);
endfunction

// lowest set bit only
function automatic logic [NUM_AC-1:0] lowest_onehot(input logic [NUM_AC-1:0] vec);
	return vec & (~vec + NUM_AC'(1));
endfunction

function automatic logic [NUM_AC-1:0] expected_grant(input logic en, input logic confirm,
	input logic [NUM_AC-1:0] req);
	return (en && !confirm) ? lowest_onehot(req) : '0;
endfunction

function automatic ac_t onehot_to_ac(input logic [NUM_AC-1:0] oh);
	ac_t ac;
	ac = AC0;
	for (int i = 0; i < NUM_AC; i++) begin
		if (oh[i]) begin
			ac = ac_t'(i);
		end
	end
	return ac;
endfunction

task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
	input logic [DATA_W-1:0] act);
	if (act !== exp) begin
		fail_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
	end
endtask

task automatic check_ptr(input string name, input logic [ADDR_W-1:0] exp,
	input logic [ADDR_W-1:0] act);
	if (act !== exp) begin
		fail_run($sformatf("MISMATCH %s expected %04h actual %04h", name, exp, act));
	end
endtask

task automatic check_onehot(input string name, input logic [NUM_AC-1:0] exp,
	input logic [NUM_AC-1:0] act);
	if (act !== exp) begin
		fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	end
endtask

`endif

// ==== verif/tb_ac_tx_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ac_tx_buf import ac_tx_pkg::*; ();

	localparam int ADDR_W = DEF_ADDR_W;
	localparam int HDR_WORDS = DEF_HDR_WORDS;
	localparam int DEPTH = 2 ** ADDR_W;
	localparam int WAIT_LIMIT = 64; // cycles per wait

	logic clk, rst_n;
	ac_t dma_ac, clear_ac;
	logic dma_wen, ev_tx_ready, clear_mpdu, clear_ampdu;
	logic frame_en, data_end_confirm, frame_info_retry;
	logic [DATA_W-1:0] dma_data;
	logic [LEN_W-1:0] pkt_len;
	logic [ADDR_W-1:0] frame_addr;
	logic ev_tx_ready_out;
	logic [NUM_AC-1:0] frame_info, rd_ac;
	logic [DATA_W-1:0] frame_data;
	logic [ADDR_W-1:0] base_ptr_ac0, base_ptr_ac1, base_ptr_ac2, base_ptr_ac3;
	logic [ADDR_W-1:0] dut_base [NUM_AC];
	string test_name;

	// cycle model of the buffer state
	logic [NUM_AC-1:0] m_armed;
	logic [CNT_W-1:0] m_cnt [NUM_AC];
	logic [ADDR_W-1:0] m_base [NUM_AC];
	logic m_retry, m_ready_q, m_data_ok;
	ac_t m_last;
	logic [DATA_W-1:0] m_data;

	`include "tb_model.svh"

	ac_tx_buf_top #(.ADDR_W(ADDR_W), .HDR_WORDS(HDR_WORDS)) uut (
		.clk(clk), .rst_n(rst_n),
		.dma_ac(dma_ac), .dma_wen(dma_wen), .dma_data(dma_data),
		.ev_tx_ready(ev_tx_ready), .ev_tx_ready_out(ev_tx_ready_out),
		.clear_mpdu(clear_mpdu), .clear_ampdu(clear_ampdu),
		.clear_ac(clear_ac), .pkt_len(pkt_len),
		.frame_en(frame_en), .frame_addr(frame_addr),
		.data_end_confirm(data_end_confirm), .frame_info_retry(frame_info_retry),
		.frame_info(frame_info), .rd_ac(rd_ac), .frame_data(frame_data),
		.base_ptr_ac0(base_ptr_ac0), .base_ptr_ac1(base_ptr_ac1),
		.base_ptr_ac2(base_ptr_ac2), .base_ptr_ac3(base_ptr_ac3)
	);

	assign dut_base[0] = base_ptr_ac0;
	assign dut_base[1] = base_ptr_ac1;
	assign dut_base[2] = base_ptr_ac2;
	assign dut_base[3] = base_ptr_ac3;

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// compare against the model, then advance it by one edge
	always @(posedge clk) begin : compare_cycle
		logic [NUM_AC-1:0] busy;
		logic [NUM_AC-1:0] grant;
		logic [NUM_AC-1:0] clr;
		if (!rst_n) begin
			m_armed = '0;
			m_retry = 1'b0;
			m_ready_q = 1'b0;
			m_data_ok = 1'b0;
			m_last = AC0;
			for (int i = 0; i < NUM_AC; i++) begin
				m_cnt[i] = '0;
				m_base[i] = '0;
				shadow_wptr[i] = '0;
			end
		end else begin
			for (int i = 0; i < NUM_AC; i++) begin
				busy[i] = (m_cnt[i] != '0);
			end
			grant = expected_grant(frame_en, data_end_confirm, m_armed | {NUM_AC{m_retry}});
			check_flag($sformatf("%s ready_out", test_name), m_ready_q, ev_tx_ready_out);
			check_onehot($sformatf("%s frame_info", test_name), lowest_onehot(busy), frame_info);
			check_onehot($sformatf("%s rd_ac", test_name), grant, rd_ac);
			for (int i = 0; i < NUM_AC; i++) begin
				check_ptr($sformatf("%s base_ptr_ac%0d", test_name, i), m_base[i], dut_base[i]);
			end
			if (m_data_ok) begin
				check_word($sformatf("%s frame_data", test_name), m_data, frame_data);
			end
			clr = '0;
			if (clear_mpdu || clear_ampdu) begin
				clr[clear_ac] = 1'b1;
			end
			for (int i = 0; i < NUM_AC; i++) begin
				if (ev_tx_ready && m_armed[i]) begin
					m_cnt[i] = m_cnt[i] + 1'b1;
				end else if (clr[i] && m_cnt[i] != '0) begin
					m_cnt[i] = m_cnt[i] - 1'b1;
				end
				if (clr[i]) begin
					m_base[i] = m_base[i] + release_words(pkt_len);
				end
			end
			if (data_end_confirm) begin
				m_armed[m_last] = 1'b0; // last read AC
			end
			if (|grant) begin
				m_last = onehot_to_ac(grant);
				m_data = shadow_mem[m_last][frame_addr]; // read before this edge's write
				m_data_ok = 1'b1;
			end
			if (dma_wen) begin
				m_armed[dma_ac] = 1'b1;
				shadow_mem[dma_ac][shadow_wptr[dma_ac]] = dma_data;
				shadow_wptr[dma_ac] = shadow_wptr[dma_ac] + 1'b1;
			end
			if (frame_info_retry) begin
				m_retry = 1'b1;
			end else if (data_end_confirm) begin
				m_retry = 1'b0;
			end
			m_ready_q = ev_tx_ready;
		end
	end

	// next falling edge with all strobes idle
	task automatic step();
		@(negedge clk);
		dma_wen = 1'b0;
		ev_tx_ready = 1'b0;
		clear_mpdu = 1'b0;
		clear_ampdu = 1'b0;
		frame_en = 1'b0;
		data_end_confirm = 1'b0;
		frame_info_retry = 1'b0;
	endtask

	task automatic dma_burst(input ac_t ac, input int n);
		for (int i = 0; i < n; i++) begin
			step();
			dma_ac = ac;
			dma_wen = 1'b1;
			dma_data = rand_bits(32);
		end
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] addr, input logic confirm);
		step();
		frame_en = 1'b1;
		frame_addr = addr;
		data_end_confirm = confirm;
	endtask

	task automatic grant_is(input logic [NUM_AC-1:0] exp);
		#1;
		check_onehot($sformatf("%s grant", test_name), exp, rd_ac);
	endtask

	task automatic wait_info(input logic [NUM_AC-1:0] exp);
		int n;
		n = 0;
		while (frame_info !== exp) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				fail_run($sformatf("timeout in %s, frame_info never reached %b", test_name, exp));
			end
		end
	endtask

	initial begin : stimulus
		int n;
		test_name = "reset";
		rst_n = 1'b0;
		dma_ac = AC0;
		clear_ac = AC0;
		dma_wen = 1'b0;
		dma_data = '0;
		ev_tx_ready = 1'b0;
		clear_mpdu = 1'b0;
		clear_ampdu = 1'b0;
		pkt_len = '0;
		frame_en = 1'b0;
		frame_addr = '0;
		data_end_confirm = 1'b0;
		frame_info_retry = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_name = "dma_readback";
		dma_burst(AC2, 24);
		for (int i = 0; i < 16; i++) begin
			read_word(ADDR_W'(rand_bits(8) % 24), 1'b0);
			grant_is(4'b0100);
		end
		read_word('0, 1'b1); // frame end, AC2 disarmed

		test_name = "ready_pending";
		dma_burst(AC1, 8);
		dma_burst(AC3, 8);
		for (int i = 0; i < 20; i++) begin
			step();
			ev_tx_ready = rand_bits(1);
		end
		step();
		ev_tx_ready = 1'b1;
		step();
		wait_info(4'b0010);

		test_name = "frame_release";
		for (int i = 0; i < 16; i++) begin
			step();
			clear_ac = ac_t'(rand_bits(2));
			pkt_len = LEN_W'(rand_bits(16));
			if (rand_bits(1)) begin
				clear_ampdu = 1'b1;
			end else begin
				clear_mpdu = 1'b1;
			end
		end
		step();
		for (int a = 0; a < NUM_AC; a++) begin
			n = m_cnt[a]; // drain what is left
			for (int k = 0; k < n; k++) begin
				step();
				clear_ac = ac_t'(a);
				pkt_len = LEN_W'(rand_bits(16));
				clear_mpdu = 1'b1;
			end
		end
		step();
		wait_info('0);

		test_name = "priority_disarm";
		read_word(ADDR_W'(rand_bits(3)), 1'b0);
		grant_is(4'b0010);
		read_word(ADDR_W'(rand_bits(3)), 1'b1);
		grant_is('0);
		read_word(ADDR_W'(rand_bits(3)), 1'b0);
		grant_is(4'b1000);
		read_word('0, 1'b1);

		test_name = "retry";
		dma_burst(AC0, 8);
		read_word('0, 1'b0);
		read_word('0, 1'b1); // nothing armed after this
		step();
		frame_info_retry = 1'b1;
		read_word(ADDR_W'(rand_bits(3)), 1'b0);
		grant_is(4'b0001);
		read_word('0, 1'b1);
		read_word(ADDR_W'(rand_bits(3)), 1'b0);
		grant_is('0);
		step();
		step();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/ac_tx_buf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// tx frame buffer, four AC RAMs with write decode, queue control and read select
module ac_tx_buf_top import ac_tx_pkg::*; #(
	parameter int ADDR_W    = DEF_ADDR_W,
	parameter int HDR_WORDS = DEF_HDR_WORDS
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire ac_t               dma_ac,
	input  wire logic              dma_wen,
	input  wire logic [DATA_W-1:0] dma_data,
	input  wire logic              ev_tx_ready,
	output logic                   ev_tx_ready_out,
	input  wire logic              clear_mpdu,
	input  wire logic              clear_ampdu,
	input  wire ac_t               clear_ac,
	input  wire logic [LEN_W-1:0]  pkt_len,
	input  wire logic              frame_en,
	input  wire logic [ADDR_W-1:0] frame_addr,
	input  wire logic              data_end_confirm,
	input  wire logic              frame_info_retry,
	output logic      [NUM_AC-1:0] frame_info,
	output logic      [NUM_AC-1:0] rd_ac,
	output logic      [DATA_W-1:0] frame_data,
	output logic      [ADDR_W-1:0] base_ptr_ac0,
	output logic      [ADDR_W-1:0] base_ptr_ac1,
	output logic      [ADDR_W-1:0] base_ptr_ac2,
	output logic      [ADDR_W-1:0] base_ptr_ac3
);

	logic [NUM_AC-1:0] mem_wen;
	logic [ADDR_W-1:0] mem_waddr;
	logic [NUM_AC-1:0] wr_strobe;
	logic [NUM_AC-1:0] mem_ren;
	logic [ADDR_W-1:0] mem_raddr;
	logic [NUM_AC-1:0] armed;
	logic [NUM_AC-1:0] disarm;
	logic [DATA_W-1:0] mem_rdata_ac0;
	logic [DATA_W-1:0] mem_rdata_ac1;
	logic [DATA_W-1:0] mem_rdata_ac2;
	logic [DATA_W-1:0] mem_rdata_ac3;

	// one RAM per access category
	tx_frame_mem #(.ADDR_W(ADDR_W)) mem_ac0 (
		.clk   (clk),
		.wen   (mem_wen[0]),
		.waddr (mem_waddr),
		.wdata (dma_data),
		.ren   (mem_ren[0]),
		.raddr (mem_raddr),
		.rdata (mem_rdata_ac0)
	);

	tx_frame_mem #(.ADDR_W(ADDR_W)) mem_ac1 (
		.clk   (clk),
		.wen   (mem_wen[1]),
		.waddr (mem_waddr),
		.wdata (dma_data),
		.ren   (mem_ren[1]),
		.raddr (mem_raddr),
		.rdata (mem_rdata_ac1)
	);

	tx_frame_mem #(.ADDR_W(ADDR_W)) mem_ac2 (
		.clk   (clk),
		.wen   (mem_wen[2]),
		.waddr (mem_waddr),
		.wdata (dma_data),
		.ren   (mem_ren[2]),
		.raddr (mem_raddr),
		.rdata (mem_rdata_ac2)
	);

	tx_frame_mem #(.ADDR_W(ADDR_W)) mem_ac3 (
		.clk   (clk),
		.wen   (mem_wen[3]),
		.waddr (mem_waddr),
		.wdata (dma_data),
		.ren   (mem_ren[3]),
		.raddr (mem_raddr),
		.rdata (mem_rdata_ac3)
	);

	dma_write_decode #(.ADDR_W(ADDR_W)) u_wr_dec (
		.clk       (clk),
		.rst_n     (rst_n),
		.dma_ac    (dma_ac),
		.dma_wen   (dma_wen),
		.mem_wen   (mem_wen),
		.mem_waddr (mem_waddr),
		.wr_strobe (wr_strobe)
	);

	frame_queue_ctrl #(.ADDR_W(ADDR_W), .HDR_WORDS(HDR_WORDS)) u_queue (
		.clk             (clk),
		.rst_n           (rst_n),
		.wr_strobe       (wr_strobe),
		.ev_tx_ready     (ev_tx_ready),
		.ev_tx_ready_out (ev_tx_ready_out),
		.clear_mpdu      (clear_mpdu),
		.clear_ampdu     (clear_ampdu),
		.clear_ac        (clear_ac),
		.pkt_len         (pkt_len),
		.disarm          (disarm),
		.armed           (armed),
		.frame_info      (frame_info),
		.base_ptr_ac0    (base_ptr_ac0),
		.base_ptr_ac1    (base_ptr_ac1),
		.base_ptr_ac2    (base_ptr_ac2),
		.base_ptr_ac3    (base_ptr_ac3)
	);

	read_select #(.ADDR_W(ADDR_W)) u_rd_sel (
		.clk              (clk),
		.rst_n            (rst_n),
		.frame_en         (frame_en),
		.frame_addr       (frame_addr),
		.data_end_confirm (data_end_confirm),
		.frame_info_retry (frame_info_retry),
		.armed            (armed),
		.rd_ac            (rd_ac),
		.mem_ren          (mem_ren),
		.mem_raddr        (mem_raddr),
		.mem_rdata_ac0    (mem_rdata_ac0),
		.mem_rdata_ac1    (mem_rdata_ac1),
		.mem_rdata_ac2    (mem_rdata_ac2),
		.mem_rdata_ac3    (mem_rdata_ac3),
		.disarm           (disarm),
		.frame_data       (frame_data)
	);

endmodule

`default_nettype wire

// ==== hw/read_select.sv ====
`timescale 1ns/1ps
`default_nettype none

// read grant for the transmit handler and the data return path
module read_select import ac_tx_pkg::*; #(
	parameter int ADDR_W = DEF_ADDR_W
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              frame_en,
	input  wire logic [ADDR_W-1:0] frame_addr,
	input  wire logic              data_end_confirm,
	input  wire logic              frame_info_retry,
	input  wire logic [NUM_AC-1:0] armed,
	output logic      [NUM_AC-1:0] rd_ac,
	output logic      [NUM_AC-1:0] mem_ren,
	output logic      [ADDR_W-1:0] mem_raddr,
	input  wire logic [DATA_W-1:0] mem_rdata_ac0,
	input  wire logic [DATA_W-1:0] mem_rdata_ac1,
	input  wire logic [DATA_W-1:0] mem_rdata_ac2,
	input  wire logic [DATA_W-1:0] mem_rdata_ac3,
	output logic      [NUM_AC-1:0] disarm,
	output logic      [DATA_W-1:0] frame_data
);

	logic              retry_q;
	logic [NUM_AC-1:0] req;
	ac_t               grant_ac;
	ac_t               last_ac; // also the data mux select
	logic [DATA_W-1:0] rdata_ac [NUM_AC];

	// retry opens every AC until the frame ends and set beats clear
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retry_q <= 1'b0;
		end else if (frame_info_retry) begin
			retry_q <= 1'b1;
		end else if (data_end_confirm) begin
			retry_q <= 1'b0;
		end
	end

	assign req = armed | {NUM_AC{retry_q}};

	// lowest requesting AC and no read in a confirm cycle
	always_comb begin
		rd_ac = '0;
		grant_ac = AC0;
		if (frame_en && !data_end_confirm) begin
			for (int i = NUM_AC - 1; i >= 0; i--) begin
				if (req[i]) begin
					rd_ac = NUM_AC'(1) << i;
					grant_ac = ac_t'(i);
				end
			end
		end
	end

	assign mem_ren = rd_ac;
	assign mem_raddr = frame_addr; // only the granted RAM reads it

	// lines up with the one-cycle RAM read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_ac <= AC0;
		end else if (|rd_ac) begin
			last_ac <= grant_ac;
		end
	end

	// end of frame releases the AC that was read last
	always_comb begin
		disarm = '0;
		if (data_end_confirm) begin
			disarm = NUM_AC'(1) << last_ac;
		end
	end

	assign rdata_ac[0] = mem_rdata_ac0;
	assign rdata_ac[1] = mem_rdata_ac1;
	assign rdata_ac[2] = mem_rdata_ac2;
	assign rdata_ac[3] = mem_rdata_ac3;

	assign frame_data = rdata_ac[last_ac]; // holds until the next grant

	a_read_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		frame_en |-> !$isunknown({data_end_confirm, frame_addr})
	) else $error("frame read with unknown address or confirm");

endmodule

`default_nettype wire

// ==== hw/frame_queue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-AC armed flags, pending frames and release pointers
module frame_queue_ctrl import ac_tx_pkg::*; #(
	parameter int ADDR_W    = DEF_ADDR_W,
	parameter int HDR_WORDS = DEF_HDR_WORDS
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic [NUM_AC-1:0] wr_strobe,
	input  wire logic              ev_tx_ready,
	output logic                   ev_tx_ready_out,
	input  wire logic              clear_mpdu,
	input  wire logic              clear_ampdu,
	input  wire ac_t               clear_ac,
	input  wire logic [LEN_W-1:0]  pkt_len,
	input  wire logic [NUM_AC-1:0] disarm,
	output logic      [NUM_AC-1:0] armed,
	output logic      [NUM_AC-1:0] frame_info,
	output logic      [ADDR_W-1:0] base_ptr_ac0,
	output logic      [ADDR_W-1:0] base_ptr_ac1,
	output logic      [ADDR_W-1:0] base_ptr_ac2,
	output logic      [ADDR_W-1:0] base_ptr_ac3
);

	logic [CNT_W-1:0]  pend_cnt [NUM_AC];
	logic [ADDR_W-1:0] base_ptr [NUM_AC];
	logic [NUM_AC-1:0] clr_hit;
	logic [ADDR_W-1:0] adv_words;

	// payload words rounded up plus the fixed header modulo depth
	assign adv_words = ADDR_W'(pkt_len[LEN_W-1:2]) + ADDR_W'(|pkt_len[1:0])
		+ ADDR_W'(HDR_WORDS);

	// which AC a clear releases this cycle
	always_comb begin
		for (int i = 0; i < NUM_AC; i++) begin
			clr_hit[i] = (clear_mpdu || clear_ampdu) && (clear_ac == ac_t'(i));
		end
	end

	// ready event echo back to the upper MAC
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ev_tx_ready_out <= 1'b0;
		end else begin
			ev_tx_ready_out <= ev_tx_ready;
		end
	end

	// armed while DMA data sits in the AC and a new write beats a disarm
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed <= '0;
		end else begin
			armed <= wr_strobe | (armed & ~disarm);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_AC; i++) begin
				pend_cnt[i] <= '0;
				base_ptr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_AC; i++) begin
				if (ev_tx_ready && armed[i]) begin
					pend_cnt[i] <= pend_cnt[i] + 1'b1; // ready beats clear
				end else if (clr_hit[i] && pend_cnt[i] != '0) begin
					pend_cnt[i] <= pend_cnt[i] - 1'b1;
				end
				if (clr_hit[i]) begin
					base_ptr[i] <= base_ptr[i] + adv_words;
				end
			end
		end
	end

	// lowest AC with pending frames wins
	always_comb begin
		frame_info = '0;
		for (int i = NUM_AC - 1; i >= 0; i--) begin
			if (pend_cnt[i] != '0) begin
				frame_info = NUM_AC'(1) << i;
			end
		end
	end

	assign base_ptr_ac0 = base_ptr[0];
	assign base_ptr_ac1 = base_ptr[1];
	assign base_ptr_ac2 = base_ptr[2];
	assign base_ptr_ac3 = base_ptr[3];

	// an increment must never leave the count at zero
	for (genvar g = 0; g < NUM_AC; g++) begin : g_cnt_chk
		a_no_wrap: assert property (
			@(posedge clk) disable iff (!rst_n)
			ev_tx_ready && armed[g] |=> pend_cnt[g] != '0
		) else $error("pending count of AC%0d wrapped", g);
	end

	a_clear_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		(clear_mpdu || clear_ampdu) |-> !$isunknown({clear_ac, pkt_len})
	) else $error("frame clear with unknown AC or length");

endmodule

`default_nettype wire

// ==== hw/dma_write_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

// steers DMA words into the RAM of the named AC and tracks where they land
module dma_write_decode import ac_tx_pkg::*; #(
	parameter int ADDR_W = DEF_ADDR_W
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire ac_t               dma_ac,
	input  wire logic              dma_wen,
	output logic      [NUM_AC-1:0] mem_wen,
	output logic      [ADDR_W-1:0] mem_waddr,
	output logic      [NUM_AC-1:0] wr_strobe
);

	logic [ADDR_W-1:0] wr_ptr [NUM_AC]; // next free word per AC

	// one-hot enable from the AC number
	always_comb begin
		mem_wen = '0;
		if (dma_wen) begin
			mem_wen = NUM_AC'(1) << dma_ac;
		end
	end

	assign mem_waddr = wr_ptr[dma_ac]; // only one RAM writes per cycle so the address is shared
	assign wr_strobe = mem_wen; // arms the AC in the queue block

	// pointers wrap at the RAM depth by width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_AC; i++) begin
				wr_ptr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_AC; i++) begin
				if (mem_wen[i]) begin
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				end
			end
		end
	end

	a_wen_known_ac: assert property (
		@(posedge clk) disable iff (!rst_n)
		dma_wen |-> !$isunknown(dma_ac)
	) else $error("dma write names an unknown AC");

endmodule

`default_nettype wire

// ==== hw/tx_frame_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// simple dual-port frame RAM, one port writes and the other reads
module tx_frame_mem import ac_tx_pkg::*; #(
	parameter int ADDR_W = DEF_ADDR_W
) (
	input  wire logic              clk,
	input  wire logic              wen,
	input  wire logic [ADDR_W-1:0] waddr,
	input  wire logic [DATA_W-1:0] wdata,
	input  wire logic              ren,
	input  wire logic [ADDR_W-1:0] raddr,
	output logic      [DATA_W-1:0] rdata
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];

	// write port, fed by the DMA stream
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// read port, one cycle latency
	always_ff @(posedge clk) begin
		if (ren) begin
			rdata <= mem[raddr]; // holds when ren is low
		end
	end

endmodule

`default_nettype wire

// ==== hw/ac_tx_pkg.sv ====
`default_nettype none

package ac_tx_pkg;

	// 802.11 EDCA access categories, AC0 has the highest read priority here
	localparam int NUM_AC = 4;

	typedef enum logic [1:0] {
		AC0 = 2'd0,
		AC1 = 2'd1,
		AC2 = 2'd2,
		AC3 = 2'd3
	} ac_t;

	// data path
	localparam int DATA_W = 32; // one DMA word
	localparam int LEN_W = 20; // packet length in bytes

	// buffer geometry
	localparam int DEF_ADDR_W = 14; // 16K words per AC

	// fixed per-frame overhead in words, released along with the payload
	localparam int DEF_HDR_WORDS = 22;

	// pending frames per AC
	localparam int CNT_W = 8;

endpackage

`default_nettype wire
